//--- project.f
+incdir+testbench
source/reg_pkg.sv
source/gpr_file.sv
source/pending_table.sv
source/writeback_control.sv
source/operand_issue.sv
source/reg_unit_top.sv
testbench/reg_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator, run it, decide from the log
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --timescale 1ns/1ps -f project.f \
	--top-module reg_unit_tb -o reg_unit_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/reg_unit_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^RESULT: PASS$" "$log"; then
	exit 0
fi
echo "pass line not found in $log"
exit 1

//--- source/gpr_file.sv
module gpr_file import reg_pkg::*; #(
	parameter int num_regs   = reg_pkg::num_regs,
	parameter int data_width = reg_pkg::data_width
) (
	input  logic                      clock_i,
	input  logic                      reset_i,
	input  logic [reg_addr_width-1:0] rd1_addr_i,
	input  logic [reg_addr_width-1:0] rd2_addr_i,
	input  logic [reg_addr_width-1:0] rd3_addr_i,
	output logic [data_width-1:0]     rd1_data_o,
	output logic [data_width-1:0]     rd2_data_o,
	output logic [data_width-1:0]     rd3_data_o,
	input  logic                      we1_i,
	input  logic [reg_addr_width-1:0] wa1_i,
	input  logic [data_width-1:0]     wd1_i,
	input  logic                      we2_i,
	input  logic [reg_addr_width-1:0] wa2_i,
	input  logic [data_width-1:0]     wd2_i,
	input  logic                      dbg_en_i,
	input  logic [reg_addr_width-1:0] dbg_addr_i,
	output logic [data_width-1:0]     dbg_data_o
);
	localparam int idx_width = $clog2(num_regs); // low address bits that select a register

	logic [data_width-1:0] regs [num_regs];

	// read ports, same-cycle write not visible until the edge
	assign rd1_data_o = regs[rd1_addr_i[idx_width-1:0]];
	assign rd2_data_o = regs[rd2_addr_i[idx_width-1:0]];
	assign rd3_data_o = regs[rd3_addr_i[idx_width-1:0]];

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			for (int i = 0; i < num_regs; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (we1_i) regs[wa1_i[idx_width-1:0]] <= wd1_i;
			if (we2_i) regs[wa2_i[idx_width-1:0]] <= wd2_i; // last one wins, port 2
		end
	end

	// debug port, one cycle latency
	always_ff @(posedge clock_i) begin
		if (dbg_en_i) dbg_data_o <= regs[dbg_addr_i[idx_width-1:0]];
	end

endmodule

//--- source/operand_issue.sv
module operand_issue import reg_pkg::*; #(
	parameter int data_width = reg_pkg::data_width
) (
	input  logic                      clock_i,
	input  logic                      reset_i,
	// instruction from decode
	input  logic                      enable_i,
	input  logic [imm_width-1:0]      imm_i,
	input  logic                      imm_en_i,
	input  logic [reg_addr_width-1:0] reg1_i, reg2_i, reg3_i,
	input  logic                      reg1_en_i, reg2_en_i, reg3_en_i,
	input  reg_use_t                  reg1_use_i, reg2_use_i, reg3_use_i,
	input  logic                      reg2_zero_sel_i,
	input  logic                      reg3_is_imm_i,
	input  logic                      bit1_i, bit2_i, bit1_en_i, bit2_en_i,
	input  logic [opcode_width-1:0]   opcode_i,
	input  logic [xopcode_width-1:0]  xopcode_i,
	input  logic                      xopcode_en_i,
	input  unit_code_t                unit_i,
	input  logic [format_width-1:0]   format_i,
	input  logic [data_width-1:0]     address_i,
	// register file and scoreboard
	input  logic [data_width-1:0]     rd1_data_i, rd2_data_i, rd3_data_i,
	input  logic                      busy1_i, busy2_i, busy3_i,
	input  logic                      mode64_i,
	output logic [reg_addr_width-1:0] rd1_addr_o, rd2_addr_o, rd3_addr_o,
	output logic                      set1_o, set2_o, set3_o,
	output logic [reg_addr_width-1:0] set1_addr_o, set2_addr_o, set3_addr_o,
	output logic                      stall_o,
	// issue to execution
	output logic                      issue_o,
	output logic [data_width-1:0]     operand1_o, operand2_o, operand3_o,
	output logic                      operand1_en_o, operand2_en_o, operand3_en_o,
	output logic                      operand1_wb_o, operand2_wb_o, operand3_wb_o,
	output logic [reg_addr_width-1:0] reg1_o, reg2_o, reg3_o,
	output logic [imm_width-1:0]      imm_o,
	output logic                      imm_en_o,
	output logic                      bit1_o, bit2_o, bit1_en_o, bit2_en_o,
	output logic [opcode_width-1:0]   opcode_o,
	output logic [xopcode_width-1:0]  xopcode_o,
	output logic                      xopcode_en_o,
	output unit_code_t                unit_o,
	output logic [format_width-1:0]   format_o,
	output logic [data_width-1:0]     address_o,
	output logic                      mode64_o
);
	logic                  zero2;                // ra|0 form with r0
	logic                  names1, names2, names3; // operand really refers to a gpr
	logic                  wb1, wb2, wb3;
	logic [data_width-1:0] val1, val2, val3;
	logic                  accept;

	// register contents for reads, else the field itself zero-extended
	function automatic logic [data_width-1:0] pick(input reg_use_t how,
			input logic [reg_addr_width-1:0] field, input logic [data_width-1:0] data);
		if (how == use_read || how == use_read_write) return data;
		return data_width'(field);
	endfunction

	//////////////////////////////////////////////////
	// hazard check
	//////////////////////////////////////////////////
	assign zero2  = reg2_zero_sel_i && (reg2_i == '0);
	assign names1 = reg1_en_i && (reg1_use_i != use_imm);
	assign names2 = reg2_en_i && (reg2_use_i != use_imm) && !zero2;
	assign names3 = reg3_en_i && (reg3_use_i != use_imm) && !reg3_is_imm_i;

	// same addresses go to the read ports and the busy lookups
	assign rd1_addr_o = reg1_i;
	assign rd2_addr_o = reg2_i;
	assign rd3_addr_o = reg3_i;

	// any named gpr in flight holds the instruction, dest included
	assign stall_o = enable_i && ((names1 && busy1_i) || (names2 && busy2_i) ||
			(names3 && busy3_i));
	assign accept  = enable_i && !stall_o;

	//////////////////////////////////////////////////
	// operand select and dest marking
	//////////////////////////////////////////////////
	assign wb1 = reg1_en_i && (reg1_use_i == use_write || reg1_use_i == use_read_write);
	assign wb2 = reg2_en_i && (reg2_use_i == use_write || reg2_use_i == use_read_write);
	assign wb3 = reg3_en_i && (reg3_use_i == use_write || reg3_use_i == use_read_write);

	assign val1 = pick(reg1_use_i, reg1_i, rd1_data_i);
	assign val2 = zero2 ? '0 : pick(reg2_use_i, reg2_i, rd2_data_i);
	assign val3 = reg3_is_imm_i ? data_width'(reg3_i) : pick(reg3_use_i, reg3_i, rd3_data_i);

	// pending set lands on the accepting edge
	assign set1_o      = accept && names1 && wb1;
	assign set2_o      = accept && names2 && wb2;
	assign set3_o      = accept && names3 && wb3;
	assign set1_addr_o = reg1_i;
	assign set2_addr_o = reg2_i;
	assign set3_addr_o = reg3_i;

	//////////////////////////////////////////////////
	// issue register
	//////////////////////////////////////////////////
	always_ff @(posedge clock_i) begin
		if (reset_i) issue_o <= 1'b0;
		else issue_o <= accept; // one-cycle pulse per accepted instruction
	end

	always_ff @(posedge clock_i) begin
		if (accept) begin
			operand1_o    <= val1;
			operand2_o    <= val2;
			operand3_o    <= val3;
			operand1_en_o <= reg1_en_i;
			operand2_en_o <= reg2_en_i;
			operand3_en_o <= reg3_en_i;
			operand1_wb_o <= wb1;
			operand2_wb_o <= wb2;
			operand3_wb_o <= wb3;
			reg1_o        <= reg1_i; // dest addresses for execution
			reg2_o        <= reg2_i;
			reg3_o        <= reg3_i;
			imm_o         <= imm_i;
			imm_en_o      <= imm_en_i;
			bit1_o        <= bit1_i;
			bit2_o        <= bit2_i;
			bit1_en_o     <= bit1_en_i;
			bit2_en_o     <= bit2_en_i;
			opcode_o      <= opcode_i;
			xopcode_o     <= xopcode_i;
			xopcode_en_o  <= xopcode_en_i;
			unit_o        <= unit_i;
			format_o      <= format_i;
			address_o     <= address_i;
			mode64_o      <= mode64_i; // mode as of acceptance
		end
	end

endmodule

//--- source/pending_table.sv
module pending_table import reg_pkg::*; #(
	parameter int num_regs = reg_pkg::num_regs
) (
	input  logic                      clock_i,
	input  logic                      reset_i,
	input  logic                      set1_i,
	input  logic                      set2_i,
	input  logic                      set3_i,
	input  logic [reg_addr_width-1:0] set1_addr_i,
	input  logic [reg_addr_width-1:0] set2_addr_i,
	input  logic [reg_addr_width-1:0] set3_addr_i,
	input  logic                      clr1_i,
	input  logic                      clr2_i,
	input  logic [reg_addr_width-1:0] clr1_addr_i,
	input  logic [reg_addr_width-1:0] clr2_addr_i,
	input  logic [reg_addr_width-1:0] q1_addr_i,
	input  logic [reg_addr_width-1:0] q2_addr_i,
	input  logic [reg_addr_width-1:0] q3_addr_i,
	output logic                      busy1_o,
	output logic                      busy2_o,
	output logic                      busy3_o
);
	localparam int idx_width = $clog2(num_regs);

	logic [num_regs-1:0] pending_q; // one bit per gpr, 1 = result still in flight

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			pending_q <= '0;
		end else begin
			// writebacks first
			if (clr1_i) pending_q[clr1_addr_i[idx_width-1:0]] <= 1'b0;
			if (clr2_i) pending_q[clr2_addr_i[idx_width-1:0]] <= 1'b0;
			// new destinations override a clear on the same edge
			if (set1_i) pending_q[set1_addr_i[idx_width-1:0]] <= 1'b1;
			if (set2_i) pending_q[set2_addr_i[idx_width-1:0]] <= 1'b1;
			if (set3_i) pending_q[set3_addr_i[idx_width-1:0]] <= 1'b1;
		end
	end

	assign busy1_o = pending_q[q1_addr_i[idx_width-1:0]];
	assign busy2_o = pending_q[q2_addr_i[idx_width-1:0]];
	assign busy3_o = pending_q[q3_addr_i[idx_width-1:0]];

endmodule

//--- source/reg_pkg.sv
package reg_pkg;

	//////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////
	localparam int data_width      = 64; // gpr width
	localparam int reg_addr_width  = 5;  // register field in the instruction
	localparam int num_regs        = 32;
	localparam int imm_width       = 16;
	localparam int opcode_width    = 6;  // primary opcode
	localparam int xopcode_width   = 10; // extended opcode
	localparam int unit_code_width = 3;
	localparam int format_width    = 5;  // instruction format index
	localparam int cr_width        = 32; // eight 4-bit cr fields

	//////////////////////////////////////////////////
	// encodings
	//////////////////////////////////////////////////

	// how an instruction uses one of its register fields
	typedef enum logic [1:0] {
		use_imm        = 2'd0, // field is a literal
		use_read       = 2'd1,
		use_write      = 2'd2, // destination only
		use_read_write = 2'd3
	} reg_use_t;

	// functional unit, for issue and for writeback source
	typedef enum logic [unit_code_width-1:0] {
		unit_fx     = 3'd0,
		unit_fp     = 3'd1, // no fp regs here
		unit_ldst   = 3'd2,
		unit_branch = 3'd3,
		unit_trap   = 3'd4
	} unit_code_t;

endpackage

//--- source/reg_unit_top.sv
module reg_unit_top import reg_pkg::*; #(
	parameter int num_regs   = reg_pkg::num_regs,
	parameter int data_width = reg_pkg::data_width
) (
	input  logic                      clock_i,
	input  logic                      reset_i,
	// instruction in
	input  logic                      enable_i,
	input  logic [imm_width-1:0]      imm_i,
	input  logic                      imm_en_i,
	input  logic [reg_addr_width-1:0] reg1_i, reg2_i, reg3_i,
	input  logic                      reg1_en_i, reg2_en_i, reg3_en_i,
	input  reg_use_t                  reg1_use_i, reg2_use_i, reg3_use_i,
	input  logic                      reg2_zero_sel_i,
	input  logic                      reg3_is_imm_i,
	input  logic                      bit1_i, bit2_i, bit1_en_i, bit2_en_i,
	input  logic [opcode_width-1:0]   opcode_i,
	input  logic [xopcode_width-1:0]  xopcode_i,
	input  logic                      xopcode_en_i,
	input  unit_code_t                unit_i,
	input  logic [format_width-1:0]   format_i,
	input  logic [data_width-1:0]     address_i,
	output logic                      stall_o,
	// issue out
	output logic                      issue_o,
	output logic [data_width-1:0]     operand1_o, operand2_o, operand3_o,
	output logic                      operand1_en_o, operand2_en_o, operand3_en_o,
	output logic                      operand1_wb_o, operand2_wb_o, operand3_wb_o,
	output logic [reg_addr_width-1:0] reg1_o, reg2_o, reg3_o,
	output logic [imm_width-1:0]      imm_o,
	output logic                      imm_en_o,
	output logic                      bit1_o, bit2_o, bit1_en_o, bit2_en_o,
	output logic [opcode_width-1:0]   opcode_o,
	output logic [xopcode_width-1:0]  xopcode_o,
	output logic                      xopcode_en_o,
	output unit_code_t                unit_o,
	output logic [format_width-1:0]   format_o,
	output logic [data_width-1:0]     address_o,
	output logic                      mode64_o,
	// writeback in
	input  unit_code_t                wb_unit_i,
	input  logic                      wb1_valid_i,
	input  logic [reg_addr_width-1:0] wb1_addr_i,
	input  logic [data_width-1:0]     wb1_data_i,
	input  logic                      wb2_valid_i,
	input  logic [reg_addr_width-1:0] wb2_addr_i,
	input  logic [data_width-1:0]     wb2_data_i,
	input  logic                      wb_mode_i,
	// debug and status
	input  logic                      dbg_en_i,
	input  logic [reg_addr_width-1:0] dbg_addr_i,
	output logic [data_width-1:0]     dbg_data_o,
	output logic [cr_width-1:0]       condition_o
);
	logic                      we1, we2; // gpr writes, also scoreboard clears
	logic [reg_addr_width-1:0] wa1, wa2;
	logic [data_width-1:0]     wd1, wd2;
	logic [reg_addr_width-1:0] rd1_addr, rd2_addr, rd3_addr;
	logic [data_width-1:0]     rd1_data, rd2_data, rd3_data;
	logic                      busy1, busy2, busy3;
	logic                      set1, set2, set3;
	logic [reg_addr_width-1:0] set1_addr, set2_addr, set3_addr;
	logic                      mode64; // live mode bit

	gpr_file #(.num_regs(num_regs), .data_width(data_width)) u_gpr_file (
		.clock_i, .reset_i,
		.rd1_addr_i(rd1_addr), .rd2_addr_i(rd2_addr), .rd3_addr_i(rd3_addr),
		.rd1_data_o(rd1_data), .rd2_data_o(rd2_data), .rd3_data_o(rd3_data),
		.we1_i(we1), .wa1_i(wa1), .wd1_i(wd1),
		.we2_i(we2), .wa2_i(wa2), .wd2_i(wd2),
		.dbg_en_i, .dbg_addr_i, .dbg_data_o
	);

	pending_table #(.num_regs(num_regs)) u_pending_table (
		.clock_i, .reset_i,
		.set1_i(set1), .set2_i(set2), .set3_i(set3),
		.set1_addr_i(set1_addr), .set2_addr_i(set2_addr), .set3_addr_i(set3_addr),
		.clr1_i(we1), .clr2_i(we2), .clr1_addr_i(wa1), .clr2_addr_i(wa2),
		.q1_addr_i(rd1_addr), .q2_addr_i(rd2_addr), .q3_addr_i(rd3_addr),
		.busy1_o(busy1), .busy2_o(busy2), .busy3_o(busy3)
	);

	writeback_control #(.data_width(data_width)) u_writeback_control (
		.*,
		.we1_o(we1), .wa1_o(wa1), .wd1_o(wd1),
		.we2_o(we2), .wa2_o(wa2), .wd2_o(wd2),
		.mode64_o(mode64)
	);

	// instruction and issue ports match the top by name
	operand_issue #(.data_width(data_width)) u_operand_issue (
		.*,
		.rd1_data_i(rd1_data), .rd2_data_i(rd2_data), .rd3_data_i(rd3_data),
		.busy1_i(busy1), .busy2_i(busy2), .busy3_i(busy3),
		.mode64_i(mode64),
		.rd1_addr_o(rd1_addr), .rd2_addr_o(rd2_addr), .rd3_addr_o(rd3_addr),
		.set1_o(set1), .set2_o(set2), .set3_o(set3),
		.set1_addr_o(set1_addr), .set2_addr_o(set2_addr), .set3_addr_o(set3_addr)
	);

endmodule

//--- source/writeback_control.sv
module writeback_control import reg_pkg::*; #(
	parameter int data_width = reg_pkg::data_width
) (
	input  logic                      clock_i,
	input  logic                      reset_i,
	input  unit_code_t                wb_unit_i,
	input  logic                      wb1_valid_i,
	input  logic [reg_addr_width-1:0] wb1_addr_i,
	input  logic [data_width-1:0]     wb1_data_i,
	input  logic                      wb2_valid_i,
	input  logic [reg_addr_width-1:0] wb2_addr_i,
	input  logic [data_width-1:0]     wb2_data_i,
	input  logic                      wb_mode_i,
	output logic                      we1_o,
	output logic [reg_addr_width-1:0] wa1_o,
	output logic [data_width-1:0]     wd1_o,
	output logic                      we2_o,
	output logic [reg_addr_width-1:0] wa2_o,
	output logic [data_width-1:0]     wd2_o,
	output logic                      mode64_o,
	output logic [cr_width-1:0]       condition_o
);
	logic cr_load; // fx port 2 carries the new cr

	// which producer may touch the gprs
	always_comb begin
		we1_o = 1'b0;
		we2_o = 1'b0;
		case (wb_unit_i)
			unit_fx:   we1_o = wb1_valid_i; // port 2 goes to the cr instead
			unit_ldst: begin
				we1_o = wb1_valid_i;
				we2_o = wb2_valid_i;
			end
			default:   ; // fp, branch, trap have no gpr result here
		endcase
	end

	assign cr_load = (wb_unit_i == unit_fx) && wb2_valid_i;

	assign wa1_o = wb1_addr_i;
	assign wd1_o = wb1_data_i;
	assign wa2_o = wb2_addr_i;
	assign wd2_o = wb2_data_i;

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			condition_o <= '0;
			mode64_o    <= 1'b1; // come up in 64-bit mode
		end else begin
			if (cr_load) condition_o <= wb2_data_i[cr_width-1:0];
			if (we1_o || we2_o) mode64_o <= wb_mode_i; // any gpr write updates the mode
		end
	end

endmodule

//--- testbench/reg_unit_checks.svh
`ifndef REG_UNIT_CHECKS_SVH
`define REG_UNIT_CHECKS_SVH

//////////////////////////////////////////////////
// reference model
//////////////////////////////////////////////////
logic [data_width-1:0] ref_regs [num_regs]; // expected gpr contents
logic [num_regs-1:0]   ref_pending;         // expected scoreboard
logic [cr_width-1:0]   ref_cr;
logic                  ref_mode;            // 1 = 64-bit mode

task automatic model_reset();
	for (int i = 0; i < num_regs; i++) begin
		ref_regs[i] = '0;
	end
	ref_pending = '0;
	ref_cr      = '0;
	ref_mode    = 1'b1;
endtask

// fx writes port 1 only, port 2 feeds the cr; ldst writes both, port 2 last
task automatic model_writeback(input unit_code_t unit, input logic v1,
		input logic [reg_addr_width-1:0] a1, input logic [data_width-1:0] d1,
		input logic v2, input logic [reg_addr_width-1:0] a2,
		input logic [data_width-1:0] d2, input logic mode);
	logic w1;
	logic w2;
	w1 = v1 && (unit == unit_fx || unit == unit_ldst);
	w2 = v2 && (unit == unit_ldst);
	if (w1) begin
		ref_regs[a1]    = d1;
		ref_pending[a1] = 1'b0;
	end
	if (w2) begin
		ref_regs[a2]    = d2;
		ref_pending[a2] = 1'b0;
	end
	if (w1 || w2) ref_mode = mode;
	if (unit == unit_fx && v2) ref_cr = d2[cr_width-1:0];
endtask

// operand refers to a gpr, excluded covers ra|0 with r0 and the imm form
function automatic logic names_reg(input logic en, input reg_use_t how, input logic excluded);
	return en && (how != use_imm) && !excluded;
endfunction

function automatic logic wb_flag(input logic en, input reg_use_t how);
	return en && (how == use_write || how == use_read_write);
endfunction

function automatic logic [data_width-1:0] operand_value(input reg_use_t how,
		input logic [reg_addr_width-1:0] field, input logic forced_zero, input logic literal);
	if (forced_zero) return '0;
	if (literal) return data_width'(field);
	if (how == use_read || how == use_read_write) return ref_regs[field];
	return data_width'(field); // literal or dest only
endfunction

function automatic logic expected_stall();
	logic zero2;
	zero2 = reg2_zero_sel_i && (reg2_i == '0);
	return enable_i && (
		(names_reg(reg1_en_i, reg1_use_i, 1'b0) && ref_pending[reg1_i]) ||
		(names_reg(reg2_en_i, reg2_use_i, zero2) && ref_pending[reg2_i]) ||
		(names_reg(reg3_en_i, reg3_use_i, reg3_is_imm_i) && ref_pending[reg3_i]));
endfunction

//////////////////////////////////////////////////
// compare tasks
//////////////////////////////////////////////////
task automatic check_data(input string name, input logic [data_width-1:0] got,
		input logic [data_width-1:0] exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("[FAIL] %s got %h expected %h", name, got, exp);
	end
endtask

task automatic check_addr(input string name, input logic [reg_addr_width-1:0] got,
		input logic [reg_addr_width-1:0] exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("[FAIL] %s got %h expected %h", name, got, exp);
	end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("[FAIL] %s got %h expected %h", name, got, exp);
	end
endtask

task automatic check_cond(input string name, input logic [cr_width-1:0] got,
		input logic [cr_width-1:0] exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("[FAIL] %s got %h expected %h", name, got, exp);
	end
endtask

`endif

//--- testbench/reg_unit_tb.sv
module reg_unit_tb import reg_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int num_tests       = 5;
	localparam int cycles_per_test = 400; // longest test is well under this
	localparam int timeout_cycles  = num_tests * cycles_per_test;

	logic                      clock_i, reset_i;
	logic                      enable_i;
	logic [imm_width-1:0]      imm_i;
	logic                      imm_en_i;
	logic [reg_addr_width-1:0] reg1_i, reg2_i, reg3_i;
	logic                      reg1_en_i, reg2_en_i, reg3_en_i;
	reg_use_t                  reg1_use_i, reg2_use_i, reg3_use_i;
	logic                      reg2_zero_sel_i, reg3_is_imm_i;
	logic                      bit1_i, bit2_i, bit1_en_i, bit2_en_i;
	logic [opcode_width-1:0]   opcode_i;
	logic [xopcode_width-1:0]  xopcode_i;
	logic                      xopcode_en_i;
	unit_code_t                unit_i;
	logic [format_width-1:0]   format_i;
	logic [data_width-1:0]     address_i;
	logic                      stall_o, issue_o;
	logic [data_width-1:0]     operand1_o, operand2_o, operand3_o;
	logic                      operand1_en_o, operand2_en_o, operand3_en_o;
	logic                      operand1_wb_o, operand2_wb_o, operand3_wb_o;
	logic [reg_addr_width-1:0] reg1_o, reg2_o, reg3_o;
	logic [imm_width-1:0]      imm_o;
	logic                      imm_en_o;
	logic                      bit1_o, bit2_o, bit1_en_o, bit2_en_o;
	logic [opcode_width-1:0]   opcode_o;
	logic [xopcode_width-1:0]  xopcode_o;
	logic                      xopcode_en_o;
	unit_code_t                unit_o;
	logic [format_width-1:0]   format_o;
	logic [data_width-1:0]     address_o;
	logic                      mode64_o;
	unit_code_t                wb_unit_i;
	logic                      wb1_valid_i, wb2_valid_i, wb_mode_i;
	logic [reg_addr_width-1:0] wb1_addr_i, wb2_addr_i;
	logic [data_width-1:0]     wb1_data_i, wb2_data_i;
	logic                      dbg_en_i;
	logic [reg_addr_width-1:0] dbg_addr_i;
	logic [data_width-1:0]     dbg_data_o;
	logic [cr_width-1:0]       condition_o;

	int errors       = 0;
	int checks       = 0;
	int tests_run    = 0;
	int tests_failed = 0;
	int cycles       = 0;

	`include "reg_unit_checks.svh"

	reg_unit_top dut_i (.*); // tb names match the top ports

	initial clock_i = 1'b0;
	always #5 clock_i = ~clock_i; // 10 ns period

	// run limit
	always @(posedge clock_i) begin
		cycles++;
		if (cycles >= timeout_cycles) begin
			$display("timeout after %0d cycles, a test did not finish", cycles);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// drive helpers
	//////////////////////////////////////////////////
	task automatic tick();
		@(posedge clock_i);
		#1; // drive point, registered outputs settled
	endtask

	// idle instruction with random pass-through fields
	task automatic new_instr();
		enable_i        = 1'b0;
		reg1_i          = '0;
		reg2_i          = '0;
		reg3_i          = '0;
		reg1_en_i       = 1'b0;
		reg2_en_i       = 1'b0;
		reg3_en_i       = 1'b0;
		reg1_use_i      = use_imm;
		reg2_use_i      = use_imm;
		reg3_use_i      = use_imm;
		reg2_zero_sel_i = 1'b0;
		reg3_is_imm_i   = 1'b0;
		imm_i           = imm_width'($urandom());
		imm_en_i        = 1'($urandom());
		bit1_i          = 1'($urandom());
		bit2_i          = 1'($urandom());
		bit1_en_i       = 1'($urandom());
		bit2_en_i       = 1'($urandom());
		opcode_i        = opcode_width'($urandom());
		xopcode_i       = xopcode_width'($urandom());
		xopcode_en_i    = 1'($urandom());
		unit_i          = unit_code_t'($urandom_range(4, 0));
		format_i        = format_width'($urandom());
		address_i       = {$urandom(), $urandom()};
	endtask

	task automatic init_inputs();
		new_instr();
		wb_unit_i   = unit_fx;
		wb1_valid_i = 1'b0;
		wb2_valid_i = 1'b0;
		wb1_addr_i  = '0;
		wb2_addr_i  = '0;
		wb1_data_i  = '0;
		wb2_data_i  = '0;
		wb_mode_i   = 1'b1;
		dbg_en_i    = 1'b0;
		dbg_addr_i  = '0;
	endtask

	// one writeback cycle, model follows at the edge
	task automatic do_writeback(input unit_code_t unit, input logic v1,
			input logic [reg_addr_width-1:0] a1, input logic [data_width-1:0] d1,
			input logic v2, input logic [reg_addr_width-1:0] a2,
			input logic [data_width-1:0] d2, input logic mode);
		wb_unit_i   = unit;
		wb1_valid_i = v1;
		wb1_addr_i  = a1;
		wb1_data_i  = d1;
		wb2_valid_i = v2;
		wb2_addr_i  = a2;
		wb2_data_i  = d2;
		wb_mode_i   = mode;
		tick();
		model_writeback(unit, v1, a1, d1, v2, a2, d2, mode);
		wb1_valid_i = 1'b0;
		wb2_valid_i = 1'b0;
	endtask

	task automatic debug_read(input logic [reg_addr_width-1:0] a);
		dbg_en_i   = 1'b1;
		dbg_addr_i = a;
		tick(); // captured at this edge
		dbg_en_i   = 1'b0;
		check_data($sformatf("dbg_data_o r%0d", a), dbg_data_o, ref_regs[a]);
	endtask

	task automatic check_all_regs();
		for (int i = 0; i < num_regs; i++) begin
			debug_read(reg_addr_width'(i));
		end
	endtask

	// offer the current fields, expect no stall, check the issue pulse
	task automatic issue_instr();
		logic                  zero2, n1, n2, n3, w1, w2, w3, mode_exp;
		logic [data_width-1:0] e1, e2, e3;
		enable_i = 1'b1;
		#1;
		check_flag("stall_o", stall_o, expected_stall());
		zero2    = reg2_zero_sel_i && (reg2_i == '0);
		n1       = names_reg(reg1_en_i, reg1_use_i, 1'b0);
		n2       = names_reg(reg2_en_i, reg2_use_i, zero2);
		n3       = names_reg(reg3_en_i, reg3_use_i, reg3_is_imm_i);
		w1       = wb_flag(reg1_en_i, reg1_use_i);
		w2       = wb_flag(reg2_en_i, reg2_use_i);
		w3       = wb_flag(reg3_en_i, reg3_use_i);
		e1       = operand_value(reg1_use_i, reg1_i, 1'b0, 1'b0);
		e2       = operand_value(reg2_use_i, reg2_i, zero2, 1'b0);
		e3       = operand_value(reg3_use_i, reg3_i, 1'b0, reg3_is_imm_i);
		mode_exp = ref_mode; // mode as seen at acceptance
		tick(); // accepting edge
		enable_i = 1'b0;
		if (n1 && w1) ref_pending[reg1_i] = 1'b1;
		if (n2 && w2) ref_pending[reg2_i] = 1'b1;
		if (n3 && w3) ref_pending[reg3_i] = 1'b1;
		check_flag("issue_o", issue_o, 1'b1);
		check_data("operand1_o", operand1_o, e1);
		check_data("operand2_o", operand2_o, e2);
		check_data("operand3_o", operand3_o, e3);
		check_flag("operand1_en_o", operand1_en_o, reg1_en_i);
		check_flag("operand2_en_o", operand2_en_o, reg2_en_i);
		check_flag("operand3_en_o", operand3_en_o, reg3_en_i);
		check_flag("operand1_wb_o", operand1_wb_o, w1);
		check_flag("operand2_wb_o", operand2_wb_o, w2);
		check_flag("operand3_wb_o", operand3_wb_o, w3);
		check_addr("reg1_o", reg1_o, reg1_i);
		check_addr("reg2_o", reg2_o, reg2_i);
		check_addr("reg3_o", reg3_o, reg3_i);
		check_data("imm_o", data_width'(imm_o), data_width'(imm_i));
		check_flag("imm_en_o", imm_en_o, imm_en_i);
		check_flag("bit1_o", bit1_o, bit1_i);
		check_flag("bit2_o", bit2_o, bit2_i);
		check_flag("bit1_en_o", bit1_en_o, bit1_en_i);
		check_flag("bit2_en_o", bit2_en_o, bit2_en_i);
		check_data("opcode_o", data_width'(opcode_o), data_width'(opcode_i));
		check_data("xopcode_o", data_width'(xopcode_o), data_width'(xopcode_i));
		check_flag("xopcode_en_o", xopcode_en_o, xopcode_en_i);
		check_data("unit_o", data_width'(unit_o), data_width'(unit_i));
		check_data("format_o", data_width'(format_o), data_width'(format_i));
		check_data("address_o", address_o, address_i);
		check_flag("mode64_o", mode64_o, mode_exp);
		tick();
		check_flag("issue_o", issue_o, 1'b0); // single-cycle pulse
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (errors > errors_before) begin
			tests_failed++;
			$display("%s: %0d errors", name, errors - errors_before);
		end else begin
			$display("%s: ok", name);
		end
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////
	task automatic reset_state();
		int e0;
		e0 = errors;
		check_flag("issue_o", issue_o, 1'b0);
		check_all_regs();
		new_instr();
		reg1_en_i  = 1'b1;
		reg1_use_i = use_read;
		reg1_i     = reg_addr_width'(1);
		issue_instr(); // mode still 1 from reset
		finish_test("reset_state", e0);
	endtask

	task automatic ldst_writeback();
		int e0;
		e0 = errors;
		// r0 gets data too, so the ra|0 form has something to hide
		for (int i = 0; i <= 4; i++) begin
			do_writeback(unit_ldst, 1'b1, reg_addr_width'(i), {$urandom(), $urandom()},
				1'b1, reg_addr_width'(i + 8), {$urandom(), $urandom()}, 1'b1);
		end
		// same target on both ports
		do_writeback(unit_ldst, 1'b1, reg_addr_width'(20), {$urandom(), $urandom()},
			1'b1, reg_addr_width'(20), {$urandom(), $urandom()}, 1'b1);
		// fp result, no gpr, no mode change
		do_writeback(unit_fp, 1'b1, reg_addr_width'(1), {$urandom(), $urandom()},
			1'b1, reg_addr_width'(2), {$urandom(), $urandom()}, 1'b0);
		check_cond("condition_o", condition_o, ref_cr);
		check_all_regs();
		finish_test("ldst_writeback", e0);
	endtask

	task automatic issue_fields();
		int e0;
		e0 = errors;
		new_instr();
		reg1_i          = reg_addr_width'(7); // dest only
		reg1_en_i       = 1'b1;
		reg1_use_i      = use_write;
		reg2_i          = '0;                 // ra|0 with r0
		reg2_en_i       = 1'b1;
		reg2_use_i      = use_read;
		reg2_zero_sel_i = 1'b1;
		reg3_i          = reg_addr_width'(3); // imm form, must not mark r3
		reg3_en_i       = 1'b1;
		reg3_use_i      = use_read_write;
		reg3_is_imm_i   = 1'b1;
		issue_instr();
		new_instr();
		reg1_i          = reg_addr_width'(3); // r3 must be free
		reg1_en_i       = 1'b1;
		reg1_use_i      = use_read;
		reg2_i          = reg_addr_width'(9); // zero select ignored off r0
		reg2_en_i       = 1'b1;
		reg2_use_i      = use_read_write;
		reg2_zero_sel_i = 1'b1;
		reg3_i          = reg_addr_width'(11);
		reg3_en_i       = 1'b1;
		reg3_use_i      = use_imm;
		issue_instr();
		finish_test("issue_fields", e0);
	endtask

	task automatic raw_hazard();
		int                    e0;
		logic [data_width-1:0] d;
		e0 = errors;
		new_instr();
		reg1_i     = reg_addr_width'(5);
		reg1_en_i  = 1'b1;
		reg1_use_i = use_write;
		issue_instr(); // r5 now in flight
		new_instr();
		reg1_i     = reg_addr_width'(5);
		reg1_en_i  = 1'b1;
		reg1_use_i = use_read;
		enable_i   = 1'b1;
		repeat (3) begin
			#1;
			check_flag("stall_o", stall_o, 1'b1);
			check_flag("issue_o", issue_o, 1'b0);
			tick();
		end
		d = {$urandom(), $urandom()};
		do_writeback(unit_ldst, 1'b1, reg_addr_width'(5), d, 1'b0, '0, '0, 1'b1);
		check_flag("issue_o", issue_o, 1'b0); // clearing edge still saw r5 busy
		issue_instr();
		check_data("operand1_o", operand1_o, d);
		finish_test("raw_hazard", e0);
	endtask

	task automatic fx_condition_mode();
		int                    e0;
		logic [data_width-1:0] d1, d2;
		e0 = errors;
		d1 = {$urandom(), $urandom()};
		d2 = {$urandom(), $urandom()};
		do_writeback(unit_fx, 1'b1, reg_addr_width'(14), d1,
			1'b1, reg_addr_width'(15), d2, 1'b0);
		check_cond("condition_o", condition_o, d2[cr_width-1:0]);
		debug_read(reg_addr_width'(14));
		debug_read(reg_addr_width'(15)); // fx port 2 leaves the gprs alone
		new_instr();
		reg1_i     = reg_addr_width'(14);
		reg1_en_i  = 1'b1;
		reg1_use_i = use_read;
		reg2_i     = reg_addr_width'(20);
		reg2_en_i  = 1'b1;
		reg2_use_i = use_read;
		issue_instr();
		check_flag("mode64_o", mode64_o, 1'b0);
		finish_test("fx_condition_mode", e0);
	endtask

	initial begin
		void'($urandom(20248));
		init_inputs();
		reset_i = 1'b1;
		repeat (4) @(posedge clock_i);
		#1;
		reset_i = 1'b0;
		model_reset();
		reset_state();
		ldst_writeback();
		issue_fields();
		raw_hazard();
		fx_condition_mode();
		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule
